// File: verilog/fft_params.svh
`ifndef FFT_PARAMS_SVH
`define FFT_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////

// Input sample width per component
`define FFT_NBITS 10

// Transform length, fixed radix-2 two stage layout
`define FFT_POINTS 4

//////////////////////////////////////////////////
// Wishbone sizing
//////////////////////////////////////////////////

`define WB_ADDR_W 3   // Word address
`define WB_DATA_W 32

// Each data word carries real in the upper half, imag in the lower
`define FFT_HALF_W 16

`endif

// File: verilog/fft_types_pkg.sv
`include "fft_params.svh"

package fft_types_pkg;

    //////////////////////////////////////////////////
    // Component widths per pipeline point
    //////////////////////////////////////////////////

    localparam int IN_W = `FFT_NBITS;      // Host samples
    localparam int S1_W = `FFT_NBITS + 1;  // After first butterfly stage
    localparam int S2_W = `FFT_NBITS + 2;  // After second stage, final

    // Complex sample at input width
    typedef struct packed {
        logic signed [IN_W-1:0] re;
        logic signed [IN_W-1:0] im;
    } cplx_in_t;

    // One bit of growth per stage, no scaling
    typedef struct packed {
        logic signed [S1_W-1:0] re;
        logic signed [S1_W-1:0] im;
    } cplx_s1_t;

    typedef struct packed {
        logic signed [S2_W-1:0] re;
        logic signed [S2_W-1:0] im;
    } cplx_s2_t;

    //////////////////////////////////////////////////
    // Whole frames, index 0 at the low end
    //////////////////////////////////////////////////

    typedef cplx_in_t [`FFT_POINTS-1:0] frame_in_t;   // Valid flag travels separately
    typedef cplx_s2_t [`FFT_POINTS-1:0] frame_out_t;  // Natural order X0..X3

endpackage

// File: verilog/wb_pkg.sv
`include "fft_params.svh"

package wb_pkg;

    //////////////////////////////////////////////////
    // Wishbone classic, host side signals
    //////////////////////////////////////////////////

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;   // High for writes
        logic [`WB_ADDR_W-1:0] adr;  // Word address
        logic [`WB_DATA_W-1:0] dat;  // Write data
    } wb_req_t;

    // Slave side, ack is a single cycle pulse
    typedef struct packed {
        logic                  ack;
        logic [`WB_DATA_W-1:0] dat;  // Read data, valid with ack
    } wb_rsp_t;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    // Last sample slot, a write here commits the frame
    localparam logic [`WB_ADDR_W-1:0] ADR_LAST_SAMPLE = `WB_ADDR_W'(`FFT_POINTS - 1);

    // Completed frame counter on the result port
    localparam logic [`WB_ADDR_W-1:0] ADR_FRAME_CNT = `WB_ADDR_W'(`FFT_POINTS);

endpackage

// File: verilog/fft_butterfly.sv
`include "fft_params.svh"

module fft_butterfly
    import fft_types_pkg::*;
#(
    parameter type in_t  = cplx_in_t,
    parameter type out_t = cplx_s1_t
) (
    input  in_t  a_i,
    input  in_t  b_i,
    input  logic twd_i,    // Multiply difference by -j
    output out_t up_o,
    output out_t down_o
);

    localparam int IN_W  = $bits(in_t) / 2;
    localparam int OUT_W = $bits(out_t) / 2;

    // Growth of exactly one bit keeps sum and difference exact
    if (OUT_W != IN_W + 1) begin : g_width_chk
        $error("fft_butterfly needs out_t one bit wider than in_t per component");
    end

    // Operands widened first, sign kept
    logic signed [OUT_W-1:0] a_re, a_im;
    logic signed [OUT_W-1:0] b_re, b_im;
    logic signed [OUT_W-1:0] dif_re, dif_im;

    assign a_re = a_i.re;
    assign a_im = a_i.im;
    assign b_re = b_i.re;
    assign b_im = b_i.im;

    assign up_o.re = a_re + b_re;  // Sum branch
    assign up_o.im = a_im + b_im;

    assign dif_re = a_re - b_re;
    assign dif_im = a_im - b_im;

    // -j * (r + ji) = i - jr
    always_comb begin
        if (twd_i) begin
            down_o.re = dif_im;
            down_o.im = -dif_re;   // Range is symmetric, no wrap
        end else begin
            down_o.re = dif_re;
            down_o.im = dif_im;
        end
    end

endmodule

// File: verilog/fft_sample_loader.sv
`include "fft_params.svh"

module fft_sample_loader
    import fft_types_pkg::*;
    import wb_pkg::*;
(
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  wb_req_t   wb_req_i,
    output wb_rsp_t   wb_rsp_o,
    output frame_in_t frame_o,
    output logic      frame_valid_o  // One cycle, with the ack of x[3]
);

    localparam int IDX_W = $clog2(`FFT_POINTS);

    logic      ack_q;
    logic      req_go;     // New access seen this cycle
    logic      wr_sample;  // Write into a sample slot
    cplx_in_t  sample_w;
    frame_in_t stage_q;    // Staging buffer, host fills it
    frame_in_t stage_d;

    assign req_go    = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign wr_sample = req_go && wb_req_i.we && (wb_req_i.adr < `WB_ADDR_W'(`FFT_POINTS));

    // Low bits of each half only
    assign sample_w.re = wb_req_i.dat[`FFT_HALF_W +: `FFT_NBITS];
    assign sample_w.im = wb_req_i.dat[0 +: `FFT_NBITS];

    //////////////////////////////////////////////////
    // Staging frame
    //////////////////////////////////////////////////

    always_comb begin
        stage_d = stage_q;
        if (wr_sample) begin
            stage_d[wb_req_i.adr[IDX_W-1:0]] = sample_w;
        end
    end

    always_ff @(posedge clk_i) begin
        stage_q <= stage_d;
        if (wr_sample && wb_req_i.adr == ADR_LAST_SAMPLE) begin
            frame_o <= stage_d;  // Includes x[3] from this very write
        end
    end

    //////////////////////////////////////////////////
    // Handshake and commit pulse
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q         <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            ack_q         <= req_go;  // Reads and 4..7 acked too
            frame_valid_o <= wr_sample && (wb_req_i.adr == ADR_LAST_SAMPLE);
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = '0;   // Write-only port

    // Ack only answers a live request
    a_ack_after_req: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $rose(ack_q) |-> $past(wb_req_i.cyc && wb_req_i.stb)
    );

endmodule

// File: verilog/fft4_core.sv
`include "fft_params.svh"

module fft4_core
    import fft_types_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  frame_in_t  frame_i,
    input  logic       frame_valid_i,
    output frame_out_t frame_o,
    output logic       result_valid_o  // frame_valid_i two cycles late
);

    cplx_s1_t s1_up_w  [2];  // Butterfly outputs, stage 1
    cplx_s1_t s1_dn_w  [2];
    cplx_s1_t s1_up_q  [2];
    cplx_s1_t s1_dn_q  [2];
    cplx_s2_t s2_w     [`FFT_POINTS];  // Already in natural order
    logic [1:0] vld_q;

    // DC bin straight from the inputs, bypassing the butterflies
    logic signed [S2_W-1:0] dc_re_w;

    //////////////////////////////////////////////////
    // Stage 1, pairs half a frame apart
    //////////////////////////////////////////////////

    // (x0, x2) plain
    fft_butterfly #(.in_t(cplx_in_t), .out_t(cplx_s1_t)) i_bf_s1_even (
        .a_i(frame_i[0]), .b_i(frame_i[2]), .twd_i(1'b0),
        .up_o(s1_up_w[0]), .down_o(s1_dn_w[0])
    );

    // (x1, x3) with -j on the difference
    fft_butterfly #(.in_t(cplx_in_t), .out_t(cplx_s1_t)) i_bf_s1_odd (
        .a_i(frame_i[1]), .b_i(frame_i[3]), .twd_i(1'b1),
        .up_o(s1_up_w[1]), .down_o(s1_dn_w[1])
    );

    always_ff @(posedge clk_i) begin
        if (frame_valid_i) begin
            s1_up_q <= s1_up_w;
            s1_dn_q <= s1_dn_w;
        end
    end

    //////////////////////////////////////////////////
    // Stage 2, outputs go straight to natural order slots
    //////////////////////////////////////////////////

    fft_butterfly #(.in_t(cplx_s1_t), .out_t(cplx_s2_t)) i_bf_s2_sum (
        .a_i(s1_up_q[0]), .b_i(s1_up_q[1]), .twd_i(1'b0),
        .up_o(s2_w[0]), .down_o(s2_w[2])      // X0, X2
    );

    fft_butterfly #(.in_t(cplx_s1_t), .out_t(cplx_s2_t)) i_bf_s2_dif (
        .a_i(s1_dn_q[0]), .b_i(s1_dn_q[1]), .twd_i(1'b0),
        .up_o(s2_w[1]), .down_o(s2_w[3])      // X1, X3
    );

    always_ff @(posedge clk_i) begin
        if (vld_q[0]) begin
            for (int k = 0; k < `FFT_POINTS; k++) begin
                frame_o[k] <= s2_w[k];
            end
        end
    end

    // Valid follows the data through both stages
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= 2'b00;
        end else begin
            vld_q <= {vld_q[0], frame_valid_i};
        end
    end

    assign result_valid_o = vld_q[1];

    assign dc_re_w = frame_i[0].re + frame_i[1].re + frame_i[2].re + frame_i[3].re;

    // Result leaves with the frame committed two cycles earlier
    a_two_cycle_latency: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        result_valid_o |-> $past(frame_valid_i, 2) && frame_o[0].re == $past(dc_re_w, 2)
    );

endmodule

// File: verilog/fft_result_port.sv
`include "fft_params.svh"

module fft_result_port
    import fft_types_pkg::*;
    import wb_pkg::*;
(
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  frame_out_t frame_i,
    input  logic       result_valid_i,
    input  wb_req_t    wb_req_i,
    output wb_rsp_t    wb_rsp_o
);

    localparam int IDX_W = $clog2(`FFT_POINTS);
    localparam int EXT_W = `FFT_HALF_W - S2_W;  // Sign bits per half

    frame_out_t            res_q;   // Last completed frame
    logic [7:0]            cnt_q;   // Completed frames, wraps
    logic                  ack_q;
    logic [`WB_DATA_W-1:0] dat_q;
    logic                  req_go;
    cplx_s2_t              sel_w;

    assign req_go = wb_req_i.cyc && wb_req_i.stb && !ack_q;
    assign sel_w  = res_q[wb_req_i.adr[IDX_W-1:0]];

    //////////////////////////////////////////////////
    // Result capture
    //////////////////////////////////////////////////

    // New frame simply overwrites, no back-pressure
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_q <= '0;
            cnt_q <= '0;
        end else if (result_valid_i) begin
            res_q <= frame_i;
            cnt_q <= cnt_q + 8'd1;
        end
    end

    //////////////////////////////////////////////////
    // Wishbone read slave
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= req_go;   // Writes acked, otherwise ignored
            if (req_go) begin
                if (wb_req_i.adr < `WB_ADDR_W'(`FFT_POINTS)) begin
                    dat_q <= {{EXT_W{sel_w.re[S2_W-1]}}, sel_w.re,
                              {EXT_W{sel_w.im[S2_W-1]}}, sel_w.im};
                end else if (wb_req_i.adr == ADR_FRAME_CNT) begin
                    dat_q <= `WB_DATA_W'(cnt_q);  // Zero-extended
                end else begin
                    dat_q <= '0;
                end
            end
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = dat_q;

    // Single cycle ack even with stb held
    a_ack_one_cycle: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        ack_q |=> !ack_q
    );

endmodule

// File: verilog/fft4_wb_top.sv
`include "fft_params.svh"

module fft4_wb_top
    import fft_types_pkg::*;
    import wb_pkg::*;
(
    input  logic    clk_i,
    input  logic    arst_n_i,
    input  wb_req_t wb_in_req_i,   // Sample writes
    output wb_rsp_t wb_in_rsp_o,
    input  wb_req_t wb_out_req_i,  // Result and counter reads
    output wb_rsp_t wb_out_rsp_o
);

    frame_in_t  frame_in;
    logic       frame_valid;
    frame_out_t frame_out;
    logic       result_valid;

    //////////////////////////////////////////////////
    // Loader, core, result port in a line
    //////////////////////////////////////////////////

    fft_sample_loader i_loader (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .wb_req_i      (wb_in_req_i),
        .wb_rsp_o      (wb_in_rsp_o),
        .frame_o       (frame_in),
        .frame_valid_o (frame_valid)
    );

    // Two registered butterfly stages
    fft4_core i_core (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .frame_i        (frame_in),
        .frame_valid_i  (frame_valid),
        .frame_o        (frame_out),
        .result_valid_o (result_valid)
    );

    fft_result_port i_result (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .frame_i        (frame_out),
        .result_valid_i (result_valid),
        .wb_req_i       (wb_out_req_i),
        .wb_rsp_o       (wb_out_rsp_o)
    );

endmodule

// File: testbench/fft4_tb.sv
`include "fft_params.svh"

module fft4_tb
    import wb_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES      = 27;  // Directed 3, extremes 2, random 20, overwrite 2
    localparam int WATCHDOG_CYCLES = 400 * NUM_FRAMES + 100;
    localparam int ACK_LIMIT       = 16;  // Cycles allowed per bus access
    localparam int POLL_LIMIT      = 20;  // Counter reads per frame
    localparam bit PORT_IN         = 1'b0;
    localparam bit PORT_OUT        = 1'b1;

    logic    clk_i;
    logic    arst_n_i;
    wb_req_t wb_in_req;
    wb_rsp_t wb_in_rsp;
    wb_req_t wb_out_req;
    wb_rsp_t wb_out_rsp;

    int xr [`FFT_POINTS];  // Frame as the host wrote it
    int xi [`FFT_POINTS];
    int er [`FFT_POINTS];  // Model transform
    int ei [`FFT_POINTS];
    int frames_done;       // Frames committed so far

    fft4_wb_top i_dut (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .wb_in_req_i  (wb_in_req),
        .wb_in_rsp_o  (wb_in_rsp),
        .wb_out_req_i (wb_out_req),
        .wb_out_rsp_o (wb_out_rsp)
    );

    always #10 clk_i = ~clk_i;  // 20 ns period

    //////////////////////////////////////////////////
    // Failure path and checks
    //////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(input string name, input logic [`WB_DATA_W-1:0] exp_w,
                              input logic [`WB_DATA_W-1:0] got_w);
        assert (got_w === exp_w) else
            abort_run($sformatf("error at %0t ns: %s expected %h, got %h",
                                $time, name, exp_w, got_w));
    endtask

    //////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////

    // Drive on falling edge, hold until ack, sample at a falling edge
    task automatic bus_cycle(input bit on_out, input bit we,
                             input logic [`WB_ADDR_W-1:0] adr,
                             input logic [`WB_DATA_W-1:0] wdat,
                             output logic [`WB_DATA_W-1:0] rdat);
        wb_req_t req;
        logic    got_ack;
        int      waited;
        string   port_name;
        req.cyc   = 1'b1;
        req.stb   = 1'b1;
        req.we    = we;
        req.adr   = adr;
        req.dat   = wdat;
        waited    = 0;
        got_ack   = 1'b0;
        port_name = on_out ? "wb_out" : "wb_in";
        @(negedge clk_i);
        if (on_out) wb_out_req = req;
        else wb_in_req = req;
        while (!got_ack && waited < ACK_LIMIT) begin
            @(negedge clk_i);
            waited++;
            got_ack = on_out ? wb_out_rsp.ack : wb_in_rsp.ack;
        end
        assert (got_ack) else
            abort_run($sformatf("%s gave no ack within %0d cycles at address %0d",
                                port_name, ACK_LIMIT, adr));
        rdat = on_out ? wb_out_rsp.dat : wb_in_rsp.dat;
        if (on_out) wb_out_req = '0;  // Release bus
        else wb_in_req = '0;
    endtask

    task automatic wb_write(input bit on_out, input logic [`WB_ADDR_W-1:0] adr,
                            input logic [`WB_DATA_W-1:0] dat);
        logic [`WB_DATA_W-1:0] unused_rd;
        bus_cycle(on_out, 1'b1, adr, dat, unused_rd);
    endtask

    task automatic wb_read(input bit on_out, input logic [`WB_ADDR_W-1:0] adr,
                           output logic [`WB_DATA_W-1:0] dat);
        bus_cycle(on_out, 1'b0, adr, '0, dat);
    endtask

    //////////////////////////////////////////////////
    // Reference DFT and frame helpers
    //////////////////////////////////////////////////

    function automatic void compute_dft();
        int ar, ai, br, bi;
        ar = xr[0] - xr[2];  // x0 - x2
        ai = xi[0] - xi[2];
        br = xr[1] - xr[3];  // x1 - x3
        bi = xi[1] - xi[3];
        er[0] = xr[0] + xr[1] + xr[2] + xr[3];
        ei[0] = xi[0] + xi[1] + xi[2] + xi[3];
        er[1] = ar + bi;     // -j(b) = (bi, -br)
        ei[1] = ai - br;
        er[2] = xr[0] - xr[1] + xr[2] - xr[3];
        ei[2] = xi[0] - xi[1] + xi[2] - xi[3];
        er[3] = ar - bi;     // +j(b) = (-bi, br)
        ei[3] = ai + br;
    endfunction

    function automatic void set_sample(input int k, input int re, input int im);
        xr[k] = re;
        xi[k] = im;
    endfunction

    function automatic int rand_sample();
        return int'($urandom_range(1023)) - 512;  // Full 10-bit signed range
    endfunction

    function automatic void random_frame();
        for (int k = 0; k < `FFT_POINTS; k++) begin
            set_sample(k, rand_sample(), rand_sample());
        end
    endfunction

    task automatic load_frame();
        for (int k = 0; k < `FFT_POINTS; k++) begin
            wb_write(PORT_IN, `WB_ADDR_W'(k), {16'(xr[k]), 16'(xi[k])});  // Last commits
        end
    endtask

    // Poll the counter until it reaches frames_done
    task automatic wait_count();
        logic [`WB_DATA_W-1:0] rd;
        int                    polls;
        polls = 0;
        rd    = '0;
        while (rd != 32'(frames_done % 256) && polls < POLL_LIMIT) begin
            wb_read(PORT_OUT, ADR_FRAME_CNT, rd);
            polls++;
        end
        assert (rd == 32'(frames_done % 256)) else
            abort_run($sformatf("frame counter stuck at %0d, waiting for %0d",
                                rd, frames_done % 256));
    endtask

    task automatic check_results();
        logic [`WB_DATA_W-1:0] rd;
        for (int k = 0; k < `FFT_POINTS; k++) begin
            wb_read(PORT_OUT, `WB_ADDR_W'(k), rd);
            check_word($sformatf("X%0d", k), {er[k][15:0], ei[k][15:0]}, rd);
        end
    endtask

    task automatic run_frame();
        load_frame();
        frames_done++;
        wait_count();
        compute_dft();
        check_results();
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        abort_run($sformatf("timeout, tests still running after %0d cycles",
                            WATCHDOG_CYCLES));
    end

    initial begin : stimulus
        logic [`WB_DATA_W-1:0] rd;
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        wb_in_req   = '0;
        wb_out_req  = '0;
        frames_done = 0;
        void'($urandom(32'h1c5a09b8));
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        // Quiet bus, zero counter
        assert (!wb_in_rsp.ack && !wb_out_rsp.ack) else
            abort_run("an ack was high right after reset");
        wb_read(PORT_OUT, ADR_FRAME_CNT, rd);
        check_word("frame_cnt", '0, rd);

        for (int k = 0; k < `FFT_POINTS; k++) set_sample(k, 0, 0);
        set_sample(0, 100, -37);  // Impulse
        run_frame();
        for (int k = 0; k < `FFT_POINTS; k++) set_sample(k, -200, 150);  // Constant
        run_frame();
        set_sample(0, 1, 2);
        set_sample(1, 3, -4);
        set_sample(2, -5, 6);
        set_sample(3, 7, 8);
        run_frame();

        // Full scale, sums reach the 12-bit limits
        for (int k = 0; k < `FFT_POINTS; k++) set_sample(k, -512, -512);
        run_frame();
        set_sample(0, 511, -512);
        set_sample(1, -512, 511);
        set_sample(2, -512, 511);
        set_sample(3, 511, -512);
        run_frame();

        repeat (20) begin
            random_frame();
            run_frame();
        end
        wb_read(PORT_OUT, ADR_FRAME_CNT, rd);
        check_word("frame_cnt", 32'(frames_done), rd);

        // Back to back, only the second survives
        random_frame();
        load_frame();
        random_frame();
        load_frame();
        frames_done += 2;
        wait_count();
        compute_dft();
        check_results();

        // Ignored accesses
        for (int a = 0; a <= 4; a++) wb_write(PORT_OUT, `WB_ADDR_W'(a), $urandom());
        for (int a = 4; a < 8; a++) wb_write(PORT_IN, `WB_ADDR_W'(a), $urandom());
        wb_read(PORT_IN, '0, rd);
        check_word("wb_in_dat", '0, rd);
        repeat (4) @(negedge clk_i);  // Past the 3 cycle commit latency
        wb_read(PORT_OUT, ADR_FRAME_CNT, rd);
        check_word("frame_cnt", 32'(frames_done), rd);
        check_results();

        $display("** PASS **");
        $finish;
    end

endmodule

// File: fft4.f
+incdir+verilog
verilog/fft_types_pkg.sv
verilog/wb_pkg.sv
verilog/fft_butterfly.sv
verilog/fft_sample_loader.sv
verilog/fft4_core.sv
verilog/fft_result_port.sv
verilog/fft4_wb_top.sv
testbench/fft4_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fft4 testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module fft4_tb \
    -f fft4.f \
    -o Vfft4_tb

# Keep going on a failing run so the result search decides
out=$(./obj_dir/Vfft4_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '** PASS **'; then
    exit 0
else
    exit 1
fi
